//--- flist.f
+incdir+include
design/pipe_pkg.sv
design/reg_file_pipe.sv
design/instr_decode.sv
design/fwd_unit.sv
design/alu.sv
design/pipe_core.sv
testbench/pipe_checker.sv
testbench/tb_pipe_core.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = tb_pipe_core
FLIST     = flist.f
BUILD_DIR = obj_dir
LOG       = sim.log
FAIL_MSG  = Finished with errors
PASS_MSG  = Finished with no errors

.PHONY: compile run clean

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(BUILD_DIR)

run: compile
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "simulation did not complete"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- testbench/tb_pipe_core.sv
`timescale 1ns/1ps
`include "pipe_params.svh"

module tb_pipe_core;

	import pipe_pkg::*;

	localparam int CLK_PERIOD = 40;
	localparam int RAND_COUNT = 300;
	localparam int MAX_GAP = 3;
	// Writebacks trail the last strobe by two cycles
	localparam int DRAIN_CYCLES = 8;
	// Directed tests plus their idle and drain cycles stay below this
	localparam int DIRECTED_SLOTS = 250;
	localparam int WATCHDOG_CYCLES = DIRECTED_SLOTS + RAND_COUNT * (MAX_GAP + 1) + 20;

	logic                   clk;
	logic                   rst_n;
	logic                   instr_valid;
	logic [`DATA_W-1:0]     instr;
	logic                   wb_valid;
	logic [`REG_ADDR_W-1:0] wb_addr;
	logic [`DATA_W-1:0]     wb_data;
	int                     err_count;
	int                     check_count;
	int                     pending;
	int                     extra_errors;
	int                     base_err;
	int                     base_checks;
	string                  test_name;

	pipe_core u_dut (
		.clk         (clk),
		.rst_n       (rst_n),
		.instr_valid (instr_valid),
		.instr       (instr),
		.wb_valid    (wb_valid),
		.wb_addr     (wb_addr),
		.wb_data     (wb_data)
	);

	pipe_checker u_checker (
		.clk         (clk),
		.rst_n       (rst_n),
		.instr_valid (instr_valid),
		.instr       (instr),
		.wb_valid    (wb_valid),
		.wb_addr     (wb_addr),
		.wb_data     (wb_data),
		.err_count   (err_count),
		.check_count (check_count),
		.pending     (pending)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	initial begin
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		$display("timeout: tests did not complete within %0d cycles", WATCHDOG_CYCLES);
		$display("Finished with errors");
		$finish;
	end

	function automatic logic [31:0] rtype_word(input logic [5:0] fn, input int rd, rs, rt);
		return {6'h00, 5'(rs), 5'(rt), 5'(rd), 5'd0, fn};
	endfunction

	function automatic logic [31:0] itype_word(input logic [5:0] op, input int rt, rs,
		input logic [15:0] imm);
		return {op, 5'(rs), 5'(rt), imm};
	endfunction

	// Mix of known and dropped encodings over a few registers to provoke hazards
	function automatic logic [31:0] random_instr();
		logic [5:0] fn_tab [6];
		int         sel;
		fn_tab = '{FN_ADD, FN_SUB, FN_AND, FN_OR, FN_SLT, 6'h27};
		sel = $urandom % 10;
		case (sel)
			0, 1, 2, 3, 4, 5:
				return rtype_word(fn_tab[$urandom % 6], $urandom % 8, $urandom % 8, $urandom % 8);
			6: return itype_word(OP_ADDI, $urandom % 8, $urandom % 8, 16'($urandom));
			7: return itype_word(OP_ORI, $urandom % 8, $urandom % 8, 16'($urandom));
			8: return itype_word(OP_LUI, $urandom % 8, 0, 16'($urandom));
			default: return itype_word(6'h23, $urandom % 8, $urandom % 8, 16'($urandom));
		endcase
	endfunction

	task automatic send_instr(input logic [31:0] ins);
		@(posedge clk);
		#2;
		instr_valid = 1'b1;
		instr       = ins;
	endtask

	task automatic idle(input int n);
		repeat (n) begin
			@(posedge clk);
			#2;
			instr_valid = 1'b0;
		end
	endtask

	task automatic load_reg(input int r, input logic [31:0] val);
		send_instr(itype_word(OP_LUI, r, 0, val[31:16]));
		send_instr(itype_word(OP_ORI, r, r, val[15:0]));
	endtask

	task automatic open_test(input string name);
		test_name   = name;
		base_err    = err_count;
		base_checks = check_count;
	endtask

	// Wait for every expected writeback, then report the test
	task automatic close_test();
		int waited;
		waited = 0;
		idle(1);
		while (pending != 0 && waited < DRAIN_CYCLES) begin
			@(posedge clk);
			#1;
			waited++;
		end
		$display("%s: %0d checks, %0d errors", test_name,
			check_count - base_checks, err_count - base_err);
	endtask

	initial begin
		rst_n        = 1'b0;
		instr_valid  = 1'b0;
		instr        = '0;
		extra_errors = 0;
		void'($urandom(32'h570a_14e3));
		repeat (2) @(posedge clk);
		#2;
		rst_n = 1'b1;

		open_test("reset state");
		idle(4);
		for (int i = 1; i < `NUM_REGS; i++) begin
			send_instr(rtype_word(FN_ADD, i, i, 0));
		end
		close_test();

		open_test("r-type operations");
		load_reg(1, 32'd5);
		load_reg(2, 32'hffff_fffd);
		load_reg(3, 32'h0f0f_00ff);
		load_reg(4, 32'h8000_0000);
		idle(2);
		send_instr(rtype_word(FN_ADD, 5, 1, 2));
		send_instr(rtype_word(FN_SUB, 6, 2, 1));
		send_instr(rtype_word(FN_AND, 7, 3, 2));
		send_instr(rtype_word(FN_OR, 8, 3, 4));
		send_instr(rtype_word(FN_SLT, 9, 2, 1));
		send_instr(rtype_word(FN_SLT, 10, 1, 2));
		send_instr(rtype_word(FN_SLT, 11, 4, 2));
		close_test();

		open_test("i-type operations");
		send_instr(itype_word(OP_ADDI, 12, 1, 16'hff9c));
		send_instr(itype_word(OP_ORI, 13, 0, 16'h8001));
		send_instr(itype_word(OP_ORI, 14, 3, 16'hf000));
		send_instr(itype_word(OP_LUI, 15, 0, 16'habcd));
		send_instr(itype_word(OP_ADDI, 16, 0, 16'h8000));
		close_test();

		open_test("forwarding chains");
		for (int gap = 0; gap <= MAX_GAP; gap++) begin
			send_instr(itype_word(OP_ADDI, 17, 0, 16'(gap + 1)));
			idle(gap);
			repeat (3) begin
				send_instr(rtype_word(FN_ADD, 17, 17, 17));
				idle(gap);
			end
			send_instr(rtype_word(FN_SUB, 18, 1, 17));
			idle(gap);
			send_instr(rtype_word(FN_OR, 19, 17, 18));
			idle(gap);
		end
		close_test();

		open_test("r0 and dropped instructions");
		send_instr(rtype_word(FN_ADD, 0, 1, 2));
		send_instr(itype_word(OP_ADDI, 0, 0, 16'h1234));
		send_instr(itype_word(6'h23, 22, 1, 16'h0004));
		send_instr(rtype_word(6'h27, 22, 1, 2));
		send_instr(rtype_word(FN_ADD, 23, 0, 0));
		send_instr(rtype_word(FN_OR, 24, 0, 1));
		send_instr(rtype_word(FN_ADD, 25, 22, 0));
		close_test();

		open_test("random stream");
		repeat (RAND_COUNT) begin
			send_instr(random_instr());
			idle($urandom % (MAX_GAP + 1));
		end
		close_test();

		if (pending != 0) begin
			$display("%0d expected writebacks never arrived", pending);
			extra_errors++;
		end
		$display("totals: %0d checks, %0d errors", check_count, err_count + extra_errors);
		if (err_count + extra_errors == 0) begin
			$display("Finished with no errors");
		end else begin
			$display("Finished with errors");
		end
		$finish;
	end

endmodule

//--- testbench/pipe_checker.sv
`timescale 1ns/1ps
`include "pipe_params.svh"

module pipe_checker (
	input  logic                   clk,
	input  logic                   rst_n,
	input  logic                   instr_valid,
	input  logic [`DATA_W-1:0]     instr,
	input  logic                   wb_valid,
	input  logic [`REG_ADDR_W-1:0] wb_addr,
	input  logic [`DATA_W-1:0]     wb_data,
	output int                     err_count,
	output int                     check_count,
	output int                     pending
);

	import pipe_pkg::*;

	logic [`DATA_W-1:0]     model [`NUM_REGS];
	logic [`REG_ADDR_W-1:0] exp_addr_q [$];
	logic [`DATA_W-1:0]     exp_data_q [$];
	int                     exp_cycle_q [$];
	int                     cycle;

	// In-order result of one instruction, returns 1 when a register is written
	function automatic logic ref_exec(
		input  logic [`DATA_W-1:0]     ins,
		input  logic [`DATA_W-1:0]     a,
		input  logic [`DATA_W-1:0]     b,
		output logic [`REG_ADDR_W-1:0] dest,
		output logic [`DATA_W-1:0]     res
	);
		logic [5:0] op;
		logic [5:0] fn;
		logic       writes;
		op     = ins[31:26];
		fn     = ins[5:0];
		writes = 1'b1;
		dest   = ins[20:16];
		res    = '0;
		case (op)
			OP_RTYPE: begin
				dest = ins[15:11];
				case (fn)
					FN_ADD:  res = a + b;
					FN_SUB:  res = a - b;
					FN_AND:  res = a & b;
					FN_OR:   res = a | b;
					FN_SLT:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
					default: writes = 1'b0;
				endcase
			end
			OP_ADDI: res = a + {{16{ins[15]}}, ins[15:0]};
			OP_ORI:  res = a | {16'h0000, ins[15:0]};
			OP_LUI:  res = {ins[15:0], 16'h0000};
			default: writes = 1'b0;
		endcase
		return writes && (dest != '0);
	endfunction

	always @(posedge clk) begin
		logic [`REG_ADDR_W-1:0] dest;
		logic [`DATA_W-1:0]     res;
		logic [`REG_ADDR_W-1:0] e_addr;
		logic [`DATA_W-1:0]     e_data;
		int                     e_cycle;
		if (!rst_n) begin
			for (int i = 0; i < `NUM_REGS; i++) begin
				model[i] = '0;
			end
			exp_addr_q.delete();
			exp_data_q.delete();
			exp_cycle_q.delete();
			cycle       = 0;
			err_count   = 0;
			check_count = 0;
		end else begin
			cycle++;
			// Results leave in order, so the oldest entry is the one due
			if (wb_valid) begin
				if (exp_addr_q.size() == 0) begin
					$display("unexpected writeback at %0t to r%0d with nothing pending",
						$time, wb_addr);
					err_count++;
				end else begin
					e_addr  = exp_addr_q.pop_front();
					e_data  = exp_data_q.pop_front();
					e_cycle = exp_cycle_q.pop_front();
					check_count++;
					if (wb_addr !== e_addr || wb_data !== e_data) begin
						$display("ERROR %0t: writeback r%0d = %h, expected r%0d = %h",
							$time, wb_addr, wb_data, e_addr, e_data);
						err_count++;
					end else if (cycle - e_cycle != 2) begin
						$display("writeback to r%0d at %0t came %0d cycles after issue, not 2",
							wb_addr, $time, cycle - e_cycle);
						err_count++;
					end
				end
			end
			if (instr_valid) begin
				if (ref_exec(instr, model[instr[25:21]], model[instr[20:16]], dest, res)) begin
					model[dest] = res;
					exp_addr_q.push_back(dest);
					exp_data_q.push_back(res);
					exp_cycle_q.push_back(cycle);
				end
			end
		end
		pending = exp_addr_q.size();
	end

endmodule

//--- design/pipe_core.sv
`timescale 1ns/1ps
`include "pipe_params.svh"

module pipe_core (
	input  logic                   clk,
	input  logic                   rst_n,
	input  logic                   instr_valid,
	input  logic [`DATA_W-1:0]     instr,
	output logic                   wb_valid,
	output logic [`REG_ADDR_W-1:0] wb_addr,
	output logic [`DATA_W-1:0]     wb_data
);

	import pipe_pkg::*;

	// Decode stage
	logic [`REG_ADDR_W-1:0] id_rs;
	logic [`REG_ADDR_W-1:0] id_rt;
	logic [`REG_ADDR_W-1:0] id_dest;
	alu_op_e                id_alu_op;
	logic                   id_use_imm;
	logic [`DATA_W-1:0]     id_imm;
	logic                   id_wr_en;
	logic [`DATA_W-1:0]     rf_a;
	logic [`DATA_W-1:0]     rf_b;
	logic [`DATA_W-1:0]     fwd_a;
	logic [`DATA_W-1:0]     fwd_b;

	// ID/EX register
	logic                   ex_wr;
	logic [`REG_ADDR_W-1:0] ex_dest;
	alu_op_e                ex_alu_op;
	logic [`DATA_W-1:0]     ex_a;
	logic [`DATA_W-1:0]     ex_b;
	logic [`DATA_W-1:0]     ex_result;

	// EX/WB register
	logic                   wb_wr;
	logic [`REG_ADDR_W-1:0] wb_dest;
	logic [`DATA_W-1:0]     wb_result;

	instr_decode u_decode (
		.instr_valid (instr_valid),
		.instr       (instr),
		.rs          (id_rs),
		.rt          (id_rt),
		.dest        (id_dest),
		.alu_op      (id_alu_op),
		.use_imm     (id_use_imm),
		.imm         (id_imm),
		.wr_en       (id_wr_en)
	);

	reg_file_pipe u_reg_file (
		.clk    (clk),
		.rst_n  (rst_n),
		.rs     (id_rs),
		.rs2    (id_rt),
		.rd_wb  (wb_dest),
		.reg_wr (wb_wr),
		.bus_w  (wb_result),
		.bus_a  (rf_a),
		.bus_b  (rf_b)
	);

	fwd_unit u_fwd (
		.rs        (id_rs),
		.rt        (id_rt),
		.reg_a     (rf_a),
		.reg_b     (rf_b),
		.ex_wr     (ex_wr),
		.wb_wr     (wb_wr),
		.ex_dest   (ex_dest),
		.wb_dest   (wb_dest),
		.ex_result (ex_result),
		.wb_result (wb_result),
		.opnd_a    (fwd_a),
		.opnd_b    (fwd_b)
	);

	alu u_alu (
		.alu_op (ex_alu_op),
		.a      (ex_a),
		.b      (ex_b),
		.result (ex_result)
	);

	// Stage write flags double as the stage valid bits
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			ex_wr <= 1'b0;
			wb_wr <= 1'b0;
		end else begin
			ex_wr <= id_wr_en;
			wb_wr <= ex_wr;
		end
	end

	// Payload moves every cycle, qualified by the flags above
	always_ff @(posedge clk) begin
		ex_dest   <= id_dest;
		ex_alu_op <= id_alu_op;
		ex_a      <= fwd_a;
		ex_b      <= id_use_imm ? id_imm : fwd_b;
		wb_dest   <= ex_dest;
		wb_result <= ex_result;
	end

	assign wb_valid = wb_wr;
	assign wb_addr  = wb_dest;
	assign wb_data  = wb_result;

	// A writeback to r0 would mean decode let one through
	a_wb_not_r0: assert property (
		@(posedge clk) disable iff (!rst_n)
		wb_valid |-> (wb_addr != '0)
	) else $error("writeback strobe with r0 as target");

endmodule

//--- design/alu.sv
`timescale 1ns/1ps
`include "pipe_params.svh"

module alu (
	input  pipe_pkg::alu_op_e  alu_op,
	input  logic [`DATA_W-1:0] a,
	input  logic [`DATA_W-1:0] b,
	output logic [`DATA_W-1:0] result
);

	import pipe_pkg::*;

	localparam int HALF_W = `DATA_W / 2;

	logic signed_lt;

	assign signed_lt = $signed(a) < $signed(b);

	always_comb begin
		case (alu_op)
			ALU_ADD: result = a + b;
			ALU_SUB: result = a - b;
			ALU_AND: result = a & b;
			ALU_OR:  result = a | b;
			ALU_SLT: result = {{(`DATA_W-1){1'b0}}, signed_lt};
			// Immediate moves to the upper half, low half cleared
			ALU_LUI: result = {b[HALF_W-1:0], {HALF_W{1'b0}}};
			default: result = a + b;
		endcase
	end

endmodule

//--- design/fwd_unit.sv
`timescale 1ns/1ps
`include "pipe_params.svh"

module fwd_unit (
	input  logic [`REG_ADDR_W-1:0] rs,
	input  logic [`REG_ADDR_W-1:0] rt,
	input  logic [`DATA_W-1:0]     reg_a,
	input  logic [`DATA_W-1:0]     reg_b,
	input  logic                   ex_wr,
	input  logic                   wb_wr,
	input  logic [`REG_ADDR_W-1:0] ex_dest,
	input  logic [`REG_ADDR_W-1:0] wb_dest,
	input  logic [`DATA_W-1:0]     ex_result,
	input  logic [`DATA_W-1:0]     wb_result,
	output logic [`DATA_W-1:0]     opnd_a,
	output logic [`DATA_W-1:0]     opnd_b
);

	// Youngest in-flight producer wins, then the older one, then the array
	function automatic logic [`DATA_W-1:0] pick_src(
		input logic [`REG_ADDR_W-1:0] src,
		input logic [`DATA_W-1:0]     reg_val
	);
		logic [`DATA_W-1:0] val;
		if (ex_wr && (ex_dest == src)) begin
			val = ex_result;
		end else if (wb_wr && (wb_dest == src)) begin
			val = wb_result;
		end else begin
			val = reg_val;
		end
		return val;
	endfunction

	// Write flags are never set for r0, so r0 always falls through
	always_comb begin
		opnd_a = pick_src(rs, reg_a);
		opnd_b = pick_src(rt, reg_b);
	end

endmodule

//--- design/instr_decode.sv
`timescale 1ns/1ps
`include "pipe_params.svh"

module instr_decode (
	input  logic                   instr_valid,
	input  logic [`DATA_W-1:0]     instr,
	output logic [`REG_ADDR_W-1:0] rs,
	output logic [`REG_ADDR_W-1:0] rt,
	output logic [`REG_ADDR_W-1:0] dest,
	output pipe_pkg::alu_op_e      alu_op,
	output logic                   use_imm,
	output logic [`DATA_W-1:0]     imm,
	output logic                   wr_en
);

	import pipe_pkg::*;

	opcode_e                opcode;
	funct_e                 funct;
	logic [`REG_ADDR_W-1:0] rd_f;
	logic [15:0]            imm16;
	logic                   known;

	// Standard MIPS field layout
	assign opcode = opcode_e'(instr[31:26]);
	assign rs     = instr[25:21];
	assign rt     = instr[20:16];
	assign rd_f   = instr[15:11];
	assign imm16  = instr[15:0];
	assign funct  = funct_e'(instr[5:0]);

	always_comb begin
		known   = 1'b1;
		alu_op  = ALU_ADD;
		use_imm = 1'b1;
		dest    = rt;
		imm     = {{(`DATA_W-16){1'b0}}, imm16};
		case (opcode)
			OP_RTYPE: begin
				use_imm = 1'b0;
				dest    = rd_f;
				case (funct)
					FN_ADD:  alu_op = ALU_ADD;
					FN_SUB:  alu_op = ALU_SUB;
					FN_AND:  alu_op = ALU_AND;
					FN_OR:   alu_op = ALU_OR;
					FN_SLT:  alu_op = ALU_SLT;
					default: known = 1'b0;
				endcase
			end
			// Sign-extended immediate
			OP_ADDI: imm = {{(`DATA_W-16){imm16[15]}}, imm16};
			OP_ORI:  alu_op = ALU_OR;
			// Upper-half placement is done in the ALU
			OP_LUI:  alu_op = ALU_LUI;
			default: known = 1'b0;
		endcase
	end

	// Dropped instructions and r0 targets never write back
	assign wr_en = instr_valid && known && (dest != '0);

endmodule

//--- design/reg_file_pipe.sv
`timescale 1ns/1ps
`include "pipe_params.svh"

module reg_file_pipe (
	input  logic                   clk,
	input  logic                   rst_n,
	input  logic [`REG_ADDR_W-1:0] rs,
	input  logic [`REG_ADDR_W-1:0] rs2,
	input  logic [`REG_ADDR_W-1:0] rd_wb,
	input  logic                   reg_wr,
	input  logic [`DATA_W-1:0]     bus_w,
	output logic [`DATA_W-1:0]     bus_a,
	output logic [`DATA_W-1:0]     bus_b
);

	logic [`DATA_W-1:0] regs [`NUM_REGS];
	logic [`NUM_REGS-1:0] dest_wr_en;

	// One-hot write enable with bit 0 tied low so r0 stays zero
	always_comb begin
		dest_wr_en = '0;
		if (reg_wr) begin
			dest_wr_en[rd_wb] = 1'b1;
		end
		dest_wr_en[0] = 1'b0;
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 0; i < `NUM_REGS; i++) begin
				regs[i] <= '0;
			end
		end else begin
			for (int i = 0; i < `NUM_REGS; i++) begin
				if (dest_wr_en[i]) begin
					regs[i] <= bus_w;
				end
			end
		end
	end

	// Plain array reads; a same-cycle write is seen only after the edge
	assign bus_a = regs[rs];
	assign bus_b = regs[rs2];

	// Decode must never hand a write to r0 down the pipe
	a_no_r0_write: assert property (
		@(posedge clk) disable iff (!rst_n)
		reg_wr |-> (rd_wb != '0)
	) else $error("register file write request to r0");

endmodule

//--- design/pipe_pkg.sv
package pipe_pkg;

	// Primary opcode field, MIPS encodings
	typedef enum logic [5:0] {
		OP_RTYPE = 6'h00,
		OP_ADDI  = 6'h08,
		OP_ORI   = 6'h0d,
		OP_LUI   = 6'h0f
	} opcode_e;

	// Funct field of R-type instructions
	typedef enum logic [5:0] {
		FN_ADD = 6'h20,
		FN_SUB = 6'h22,
		FN_AND = 6'h24,
		FN_OR  = 6'h25,
		FN_SLT = 6'h2a
	} funct_e;

	// Operation selected for the ALU
	typedef enum logic [2:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_SLT,
		ALU_LUI
	} alu_op_e;

endpackage

//--- include/pipe_params.svh
`ifndef PIPE_PARAMS_SVH
`define PIPE_PARAMS_SVH

// Datapath width
`define DATA_W 32

// Register file addressing
`define REG_ADDR_W 5
`define NUM_REGS 32

`endif
